/* Makefile */
# Verilator build and run of the peripheral clock and reset control testbench

TOP := rcc_per_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* clk_gate_cell.sv */
// latch-based glitch-free clock gate with test bypass
`default_nettype none

module clk_gate_cell (
  input  wire logic raw_clk,
  input  wire logic active,
  input  wire logic bypass,
  output wire logic gen_clk
);

  logic en_lat;

  // transparent in the low phase, enable frozen while clock is high
  always_latch begin
    if (!raw_clk) begin
      en_lat <= active || bypass;
    end
  end

  assign gen_clk = raw_clk && en_lat;  // whole pulses only

endmodule

`default_nettype wire

/* compile.f */
rcc_pkg.sv
clk_gate_cell.sv
per_rst_clk_seq.sv
per_clk_rst_control.sv
rcc_reg_file.sv
rcc_per_top.sv
rcc_per_checker.sv
rcc_per_tb.sv

/* per_clk_rst_control.sv */
// per-peripheral bus clock enable, reset source select, reset sequencer and clock gate
`default_nettype none

module per_clk_rst_control #(
  parameter rcc_pkg::per_cfg_t CFG = '{
    domain:        2'd1,
    assigned_cpu1: 1'b0,
    assigned_cpu2: 1'b0,
    support_lpen:  1'b0,
    support_amen:  1'b0
  },
  parameter int CLK_ON_DELAY = 2
) (
  input  wire logic               bus_clk,
  input  wire logic               rst_n,
  input  wire rcc_pkg::per_ctrl_t ctrl,
  input  wire rcc_pkg::lp_state_t lp,
  input  wire logic               arcg_on,
  input  wire logic               testmode,
  input  wire logic               d1_rst_n,
  input  wire logic               d2_rst_n,
  output wire logic               per_clk,
  output wire logic               per_rst_n
);

  logic c1_lp_ok;    // sleep does not stop the clock
  logic c2_lp_ok;
  logic c1_clk_en;
  logic c2_clk_en;
  logic d3_clk_en;
  logic seq_clk_en;
  logic bus_clk_en;
  logic src_rst_n;

  generate
    if (CFG.support_lpen) begin : g_lpen
      assign c1_lp_ok = !lp.c1_sleep || ctrl.c1_lpen;
      assign c2_lp_ok = !lp.c2_sleep || ctrl.c2_lpen;  // own CPU's sleep level
    end else begin : g_no_lpen
      assign c1_lp_ok = 1'b1;
      assign c2_lp_ok = 1'b1;
    end

    // cpu1 demand
    if (CFG.assigned_cpu1) begin : g_cpu1_assigned
      assign c1_clk_en = c1_lp_ok && !lp.c1_deepsleep;
    end else begin : g_cpu1_reg
      assign c1_clk_en = ctrl.c1_en && c1_lp_ok && !lp.c1_deepsleep;
    end

    // cpu2 demand
    if (CFG.assigned_cpu2) begin : g_cpu2_assigned
      assign c2_clk_en = c2_lp_ok && !lp.c2_deepsleep;
    end else begin : g_cpu2_reg
      assign c2_clk_en = ctrl.c2_en && c2_lp_ok && !lp.c2_deepsleep;
    end

    // autonomous d3 demand
    if (CFG.domain == 2'd3 && CFG.support_amen) begin : g_d3_amen
      assign d3_clk_en = ctrl.amen && !lp.d3_deepsleep;
    end else begin : g_d3_default
      assign d3_clk_en = !lp.d3_deepsleep;
    end

    // reset source per domain
    if (CFG.domain == 2'd1) begin : g_rst_d1
      assign src_rst_n = !ctrl.sft_rst && d1_rst_n;
    end else if (CFG.domain == 2'd2) begin : g_rst_d2
      assign src_rst_n = !ctrl.sft_rst && d2_rst_n;
    end else begin : g_rst_d3
      assign src_rst_n = !ctrl.sft_rst;  // d3 has no domain reset here
    end
  endgenerate

  assign bus_clk_en = (c1_clk_en || c2_clk_en || d3_clk_en) && seq_clk_en;

  per_rst_clk_seq #(
    .DELAY(CLK_ON_DELAY)
  ) u_seq (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .src_rst_n (src_rst_n),
    .arcg_on   (arcg_on),
    .clk_en    (seq_clk_en),
    .sync_rst_n(per_rst_n)
  );

  clk_gate_cell u_gate (
    .raw_clk(bus_clk),
    .active (bus_clk_en),
    .bypass (testmode),
    .gen_clk(per_clk)
  );

endmodule

`default_nettype wire

/* per_rst_clk_seq.sv */
// reset release synchroniser and delayed clock-on sequencer
`default_nettype none

module per_rst_clk_seq #(
  parameter int DELAY = 2
) (
  input  wire logic bus_clk,
  input  wire logic rst_n,
  input  wire logic src_rst_n,
  input  wire logic arcg_on,
  output wire logic clk_en,
  output wire logic sync_rst_n
);
  import rcc_pkg::*;

  // counter holds DELAY-1 down to 0
  localparam int CNT_W = (DELAY > 1) ? $clog2(DELAY) : 1;

  rst_seq_e         state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             sync_q1;
  logic             sync_q2;

  // two-flop release, cleared on the first edge the source is low
  always_ff @(posedge bus_clk) begin
    if (!rst_n || !src_rst_n) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= 1'b1;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      state_q <= SEQ_HOLD;
      cnt_q   <= '0;
    end else if (!src_rst_n) begin
      state_q <= SEQ_HOLD;  // any drop restarts the sequence
      cnt_q   <= '0;
    end else begin
      case (state_q)
        SEQ_HOLD: begin
          state_q <= SEQ_SYNC;
        end
        SEQ_SYNC: begin
          // second flop rises on this edge
          if (sync_q1) begin
            state_q <= (DELAY == 0) ? SEQ_RUN : SEQ_WAIT;
            cnt_q   <= CNT_W'(DELAY - 1);
          end
        end
        SEQ_WAIT: begin
          if (cnt_q == '0) begin
            state_q <= SEQ_RUN;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: begin
          state_q <= SEQ_RUN;
        end
      endcase
    end
  end

  // source drop cuts the clock at once, arcg off keeps it on
  assign clk_en     = !arcg_on || (state_q == SEQ_RUN && src_rst_n);
  assign sync_rst_n = sync_q2;

endmodule

`default_nettype wire

/* rcc_input.txt */
// columns: c1_en c1_lpen c2_en c2_lpen amen sft_rst lp arcg_on testmode d1_rst_n d2_rst_n exp_clk exp_rst
// masks carry peripheral i in bit i; lp: 10 c1_sleep 08 c1_deep 04 c2_sleep 02 c2_deep 01 d3_deep
0 0 0 0 0 F 00 1 0 1 1 0 0
0 0 0 0 0 F 00 1 1 1 1 F 0
0 0 0 0 0 0 00 1 0 1 1 B F
0 0 0 0 0 0 01 1 0 1 1 2 F
9 0 0 0 0 0 01 1 0 1 1 B F
9 0 0 0 0 0 11 1 0 1 1 A F
9 1 0 0 0 0 11 1 0 1 1 B F
9 1 0 0 0 0 19 1 0 1 1 2 F
0 0 1 0 0 0 05 1 0 1 1 2 F
0 0 1 1 0 0 05 1 0 1 1 3 F
0 0 1 1 0 0 03 1 0 1 1 0 F
0 0 0 0 4 0 00 1 0 1 1 F F
0 0 0 0 4 0 01 1 0 1 1 2 F
0 0 0 0 0 0 00 1 0 1 1 B F
0 0 0 0 0 0 00 1 0 1 0 9 D
0 0 0 0 0 0 00 0 0 1 0 B D
0 0 0 0 0 0 00 1 0 0 1 A E
0 0 0 0 4 4 00 1 0 1 1 B B
0 0 0 0 0 F 00 1 1 1 1 F 0
0 0 0 0 0 F 00 0 0 1 1 B 0

/* rcc_per_checker.sv */
// concurrent assertions on reset release, clock-enable ordering and sequencer state
`default_nettype none

module rcc_per_checker (
  input wire logic              bus_clk,
  input wire logic              rst_n,
  input wire logic              src_rst_n,
  input wire logic              arcg_on,
  input wire logic              clk_en,
  input wire logic              sync_rst_n,
  input wire rcc_pkg::rst_seq_e state_q
);
  timeunit 1ns;
  timeprecision 1ps;
  import rcc_pkg::*;

  // with gating on, the clock only comes back after the released reset
  property p_clk_after_release;
    @(posedge bus_clk) disable iff (!rst_n)
      (arcg_on && $rose(clk_en)) |-> sync_rst_n;
  endproperty

  property p_rst_follows_src;
    @(posedge bus_clk) disable iff (!rst_n)
      !src_rst_n |=> !sync_rst_n;  // one edge to assert
  endproperty

  // delay and run states only reachable past the synchroniser
  property p_state_valid;
    @(posedge bus_clk) disable iff (!rst_n)
      (state_q inside {SEQ_WAIT, SEQ_RUN}) |-> sync_rst_n;
  endproperty

  a_clk_after_release: assert property (p_clk_after_release)
    else $error("clk_en rose while sync_rst_n was low and arcg_on was set");

  a_rst_follows_src: assert property (p_rst_follows_src)
    else $error("sync_rst_n still high one cycle after src_rst_n dropped");

  a_state_valid: assert property (p_state_valid)
    else $error("reset sequencer past the synchroniser while sync_rst_n was low");

endmodule

bind per_rst_clk_seq rcc_per_checker u_checker (
  .bus_clk   (bus_clk),
  .rst_n     (rst_n),
  .src_rst_n (src_rst_n),
  .arcg_on   (arcg_on),
  .clk_en    (clk_en),
  .sync_rst_n(sync_rst_n),
  .state_q   (state_q)
);

`default_nettype wire

/* rcc_per_tb.sv */
// testbench for the peripheral clock and reset control: vector writes, levels, gated clock edge counts
`default_nettype none

module rcc_per_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rcc_pkg::*;

  localparam int NUM_PER        = 4;
  localparam int CLK_ON_DELAY   = 2;
  localparam int CLK_PERIOD     = 100;
  localparam int NUM_VEC        = 20;
  localparam int NUM_FIELDS     = 13;
  localparam int SETTLE_CYCLES  = 16;
  localparam int COUNT_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = NUM_VEC * 40 + 100;

  // column positions within one vector
  localparam int F_C1_EN   = 0;
  localparam int F_C1_LPEN = 1;
  localparam int F_C2_EN   = 2;
  localparam int F_C2_LPEN = 3;
  localparam int F_AMEN    = 4;
  localparam int F_SFT_RST = 5;
  localparam int F_LP      = 6;
  localparam int F_ARCG    = 7;
  localparam int F_TEST    = 8;
  localparam int F_D1_RST  = 9;
  localparam int F_D2_RST  = 10;
  localparam int F_EXP_CLK = 11;
  localparam int F_EXP_RST = 12;

  logic               bus_clk = 1'b0;
  logic               rst_n;
  logic               wr_en;
  rcc_reg_e           wr_reg;
  logic [NUM_PER-1:0] wr_data;
  lp_state_t          lp;
  logic               arcg_on;
  logic               testmode;
  logic               d1_rst_n;
  logic               d2_rst_n;
  logic [NUM_PER-1:0] per_clk;
  logic [NUM_PER-1:0] per_rst_n;

  logic [7:0]  vec_mem [NUM_VEC*NUM_FIELDS];
  int unsigned edge_cnt [NUM_PER];  // free-running, read as differences
  int          n_checks = 0;
  int          n_errors = 0;

  rcc_per_top #(
    .NUM_PER     (NUM_PER),
    .CLK_ON_DELAY(CLK_ON_DELAY)
  ) DUT (
    .bus_clk  (bus_clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_reg   (wr_reg),
    .wr_data  (wr_data),
    .lp       (lp),
    .arcg_on  (arcg_on),
    .testmode (testmode),
    .d1_rst_n (d1_rst_n),
    .d2_rst_n (d2_rst_n),
    .per_clk  (per_clk),
    .per_rst_n(per_rst_n)
  );

  initial begin
    forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
  end

  // gated clock pulses only rise with bus_clk, so negedge reads are safe
  for (genvar i = 0; i < NUM_PER; i++) begin : g_edge
    always @(posedge per_clk[i]) begin
      edge_cnt[i] <= edge_cnt[i] + 1;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAILED at %0d ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task automatic write_reg(input rcc_reg_e sel, input logic [NUM_PER-1:0] data);
    @(negedge bus_clk);
    wr_en   = 1'b1;
    wr_reg  = sel;
    wr_data = data;
  endtask

  task automatic run_vector(input int v);
    logic [7:0]         field [NUM_FIELDS];
    int unsigned        start_cnt [NUM_PER];
    logic [NUM_PER-1:0] exp_clk;
    logic [NUM_PER-1:0] exp_rst;
    int unsigned        n_edges;
    for (int k = 0; k < NUM_FIELDS; k++) begin
      field[k] = vec_mem[v * NUM_FIELDS + k];
    end
    exp_clk = field[F_EXP_CLK][NUM_PER-1:0];
    exp_rst = field[F_EXP_RST][NUM_PER-1:0];
    write_reg(REG_C1_EN, field[F_C1_EN][NUM_PER-1:0]);
    write_reg(REG_C1_LPEN, field[F_C1_LPEN][NUM_PER-1:0]);
    write_reg(REG_C2_EN, field[F_C2_EN][NUM_PER-1:0]);
    write_reg(REG_C2_LPEN, field[F_C2_LPEN][NUM_PER-1:0]);
    write_reg(REG_AMEN, field[F_AMEN][NUM_PER-1:0]);
    write_reg(REG_SFT_RST, field[F_SFT_RST][NUM_PER-1:0]);
    @(negedge bus_clk);
    wr_en    = 1'b0;
    lp       = field[F_LP][4:0];
    arcg_on  = field[F_ARCG][0];
    testmode = field[F_TEST][0];
    d1_rst_n = field[F_D1_RST][0];
    d2_rst_n = field[F_D2_RST][0];
    // sync, clock-on delay and gate latch all settle well inside this
    repeat (SETTLE_CYCLES) @(negedge bus_clk);
    for (int i = 0; i < NUM_PER; i++) begin
      start_cnt[i] = edge_cnt[i];
    end
    repeat (COUNT_CYCLES) @(negedge bus_clk);
    for (int i = 0; i < NUM_PER; i++) begin
      n_edges = edge_cnt[i] - start_cnt[i];
      check(n_edges, exp_clk[i] ? 32'(COUNT_CYCLES) : 32'd0,
            $sformatf("vector %0d per_clk[%0d] edge count", v, i));
    end
    check(32'(per_rst_n), 32'(exp_rst), $sformatf("vector %0d per_rst_n mask", v));
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst_n    = 1'b0;
    wr_en    = 1'b0;
    wr_reg   = REG_C1_EN;
    wr_data  = '0;
    lp       = '0;
    arcg_on  = 1'b1;
    testmode = 1'b0;
    d1_rst_n = 1'b1;
    d2_rst_n = 1'b1;
    $readmemh("rcc_input.txt", vec_mem);
    repeat (10) @(negedge bus_clk);
    rst_n = 1'b1;
    @(negedge bus_clk);
    check(32'(per_rst_n), 32'd0, "per_rst_n just after reset");  // every peripheral held
    for (int v = 0; v < NUM_VEC; v++) begin
      run_vector(v);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rcc_per_top.sv */
// peripheral clock and reset control top: register file and one controller per peripheral
`default_nettype none

module rcc_per_top #(
  parameter int NUM_PER      = 4,
  parameter int CLK_ON_DELAY = 2,
  parameter rcc_pkg::per_cfg_t [NUM_PER-1:0] PER_CFG = '{
    // d1, lpen
    0: '{domain: 2'd1, assigned_cpu1: 1'b0, assigned_cpu2: 1'b0,
         support_lpen: 1'b1, support_amen: 1'b0},
    // d2, owned by cpu2
    1: '{domain: 2'd2, assigned_cpu1: 1'b0, assigned_cpu2: 1'b1,
         support_lpen: 1'b0, support_amen: 1'b0},
    // d3 with autonomous mode
    2: '{domain: 2'd3, assigned_cpu1: 1'b0, assigned_cpu2: 1'b0,
         support_lpen: 1'b0, support_amen: 1'b1},
    // d3, clocked unless d3 deep sleep
    3: '{domain: 2'd3, assigned_cpu1: 1'b0, assigned_cpu2: 1'b0,
         support_lpen: 1'b0, support_amen: 1'b0}
  }
) (
  input  wire logic                     bus_clk,
  input  wire logic                     rst_n,
  input  wire logic                     wr_en,
  input  wire rcc_pkg::rcc_reg_e        wr_reg,
  input  wire logic     [NUM_PER-1:0]   wr_data,
  input  wire rcc_pkg::lp_state_t       lp,
  input  wire logic                     arcg_on,
  input  wire logic                     testmode,
  input  wire logic                     d1_rst_n,
  input  wire logic                     d2_rst_n,
  output wire logic     [NUM_PER-1:0]   per_clk,
  output wire logic     [NUM_PER-1:0]   per_rst_n
);
  import rcc_pkg::*;

  per_ctrl_t [NUM_PER-1:0] per_ctrl;

  rcc_reg_file #(
    .NUM_PER(NUM_PER)
  ) u_reg_file (
    .bus_clk (bus_clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_reg  (wr_reg),
    .wr_data (wr_data),
    .per_ctrl(per_ctrl)
  );

  for (genvar i = 0; i < NUM_PER; i++) begin : g_per
    per_clk_rst_control #(
      .CFG         (PER_CFG[i]),
      .CLK_ON_DELAY(CLK_ON_DELAY)
    ) u_ctrl (
      .bus_clk  (bus_clk),
      .rst_n    (rst_n),
      .ctrl     (per_ctrl[i]),
      .lp       (lp),
      .arcg_on  (arcg_on),
      .testmode (testmode),
      .d1_rst_n (d1_rst_n),
      .d2_rst_n (d2_rst_n),
      .per_clk  (per_clk[i]),
      .per_rst_n(per_rst_n[i])
    );
  end

endmodule

`default_nettype wire

/* rcc_pkg.sv */
// rcc types: register opcodes, sequencer states, peripheral config, control and low-power structs
`default_nettype none

package rcc_pkg;

  // register field width, so at most this many peripherals
  localparam int NUM_PER_MAX = 8;

  // register opcodes, one bit per peripheral in each register
  typedef enum logic [2:0] {
    REG_C1_EN   = 3'd0,
    REG_C1_LPEN = 3'd1,
    REG_C2_EN   = 3'd2,
    REG_C2_LPEN = 3'd3,
    REG_AMEN    = 3'd4,
    REG_SFT_RST = 3'd5
  } rcc_reg_e;

  // reset release and clock-on sequence
  typedef enum logic [1:0] {
    SEQ_HOLD = 2'd0,  // reset asserted
    SEQ_SYNC = 2'd1,  // release going through the synchroniser
    SEQ_WAIT = 2'd2,  // clock-on delay running
    SEQ_RUN  = 2'd3   // released, clock allowed
  } rst_seq_e;

  // static attributes of one peripheral
  typedef struct packed {
    logic [1:0] domain;         // 1, 2 or 3
    logic       assigned_cpu1;  // implicit CPU1 allocation
    logic       assigned_cpu2;  // implicit CPU2 allocation
    logic       support_lpen;
    logic       support_amen;
  } per_cfg_t;

  // register bits of one peripheral
  typedef struct packed {
    logic c1_en;
    logic c1_lpen;
    logic c2_en;
    logic c2_lpen;
    logic amen;
    logic sft_rst;  // high holds the peripheral in reset
  } per_ctrl_t;

  // sleep levels from the power controller
  typedef struct packed {
    logic c1_sleep;
    logic c1_deepsleep;
    logic c2_sleep;
    logic c2_deepsleep;
    logic d3_deepsleep;
  } lp_state_t;

endpackage

`default_nettype wire

/* rcc_reg_file.sv */
// write-strobe register file for enable, low-power enable, autonomous enable and software reset
`default_nettype none

module rcc_reg_file #(
  parameter int NUM_PER = rcc_pkg::NUM_PER_MAX
) (
  input  wire logic                                bus_clk,
  input  wire logic                                rst_n,
  input  wire logic                                wr_en,
  input  wire rcc_pkg::rcc_reg_e                   wr_reg,
  input  wire logic               [NUM_PER-1:0]    wr_data,
  output rcc_pkg::per_ctrl_t      [NUM_PER-1:0]    per_ctrl
);
  import rcc_pkg::*;

  logic [NUM_PER-1:0] c1_en_q;
  logic [NUM_PER-1:0] c1_lpen_q;
  logic [NUM_PER-1:0] c2_en_q;
  logic [NUM_PER-1:0] c2_lpen_q;
  logic [NUM_PER-1:0] amen_q;
  logic [NUM_PER-1:0] sft_rst_q;

  // opcode decode, whole register written at once
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      c1_en_q   <= '0;
      c1_lpen_q <= '0;
      c2_en_q   <= '0;
      c2_lpen_q <= '0;
      amen_q    <= '0;
      sft_rst_q <= '1;  // all peripherals start in reset
    end else if (wr_en) begin
      case (wr_reg)
        REG_C1_EN: begin
          c1_en_q <= wr_data;
        end
        REG_C1_LPEN: begin
          c1_lpen_q <= wr_data;
        end
        REG_C2_EN: begin
          c2_en_q <= wr_data;
        end
        REG_C2_LPEN: begin
          c2_lpen_q <= wr_data;
        end
        REG_AMEN: begin
          amen_q <= wr_data;
        end
        REG_SFT_RST: begin
          sft_rst_q <= wr_data;
        end
        default: begin
          // unmapped opcode, write dropped
        end
      endcase
    end
  end

  // one control struct per peripheral, bit i of every register
  always_comb begin
    for (int i = 0; i < NUM_PER; i++) begin
      per_ctrl[i].c1_en   = c1_en_q[i];
      per_ctrl[i].c1_lpen = c1_lpen_q[i];
      per_ctrl[i].c2_en   = c2_en_q[i];
      per_ctrl[i].c2_lpen = c2_lpen_q[i];
      per_ctrl[i].amen    = amen_q[i];
      per_ctrl[i].sft_rst = sft_rst_q[i];
    end
  end

endmodule

`default_nettype wire
